//--- flist.f
verilog/rob_pkg.sv
verilog/rob_ptrs.sv
verilog/rob_recovery_fsm.sv
verilog/rob_table.sv
verilog/free_list.sv
verilog/rename_retire_top.sv
testbench/rename_retire_checker.sv
testbench/rename_retire_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module rename_retire_tb -f flist.f -o rename_retire_sim

out=$(./obj_dir/rename_retire_sim)
echo "$out"

echo "$out" | grep -qx "=== PASS ==="

//--- testbench/rename_retire_checker.sv
module rename_retire_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dispatch_valid,
    input  logic                           dispatch_ready,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  dispatch_tag,
    input  logic [rob_pkg::PREG_W-1:0]     dispatch_pd_new,
    input  logic [rob_pkg::PREG_W-1:0]     dispatch_pd_old,
    input  logic [31:0]                    dispatch_pc,
    input  logic                           fu_alu_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_alu_tag,
    input  logic                           fu_b_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_b_tag,
    input  logic                           fu_mem_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_mem_tag,
    input  logic                           br_mispredict,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  br_mispredict_tag,
    input  logic                           retire_valid,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  retire_tag,
    input  logic [rob_pkg::PREG_W-1:0]     retire_pd_old,
    input  logic [31:0]                    retire_pc,
    output int                             errors
);

    typedef struct {
        logic [rob_pkg::ROB_TAG_W-1:0] tag;
        logic [rob_pkg::PREG_W-1:0]    pd_new;
        logic [rob_pkg::PREG_W-1:0]    pd_old;
        logic [31:0]                   pc;
        logic                          done;
    } entry_t;

    entry_t                        rob_q[$];
    entry_t                        squash_q[$];
    logic [rob_pkg::PREG_W-1:0]    fl_q[$];
    logic [rob_pkg::ROB_TAG_W-1:0] tail_m;
    logic                          rv_exp;
    entry_t                        rv_entry;

    initial errors = 0;

    task automatic check(input logic ok, input string what);
        if (!ok) begin
            errors++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    function automatic void mark(input logic [rob_pkg::ROB_TAG_W-1:0] tag);
        foreach (rob_q[i]) begin
            if (rob_q[i].tag == tag) rob_q[i].done = 1'b1;
        end
    endfunction

    task automatic step();
        logic   idle_m;
        logic   ready_m;
        logic   retire_now;
        logic   take;
        entry_t e;
        entry_t sq;
        int     idx;
        check(retire_valid == rv_exp, $sformatf("retire_valid %0b, model %0b",
            retire_valid, rv_exp));
        if (rv_exp && retire_valid) begin
            check(retire_tag == rv_entry.tag && retire_pd_old == rv_entry.pd_old &&
                retire_pc == rv_entry.pc,
                $sformatf("retired tag %0d p%0d pc %h, model %0d p%0d %h",
                retire_tag, retire_pd_old, retire_pc, rv_entry.tag, rv_entry.pd_old,
                rv_entry.pc));
        end
        // no walk pending before this edge
        idle_m = squash_q.size() == 0;
        ready_m = rob_q.size() < 16 && fl_q.size() > 0 && idle_m && !br_mispredict;
        check(dispatch_ready == ready_m, $sformatf("dispatch_ready %0b, model %0b",
            dispatch_ready, ready_m));
        retire_now = idle_m && !br_mispredict && rob_q.size() > 0 && rob_q[0].done;
        take = dispatch_valid && dispatch_ready && fl_q.size() > 0;
        if (take) begin
            check(dispatch_tag == tail_m && dispatch_pd_new == fl_q[0], $sformatf(
                "dispatch tag %0d p%0d, model %0d p%0d", dispatch_tag, dispatch_pd_new,
                tail_m, fl_q[0]));
            e.tag = tail_m;
            e.pd_new = fl_q.pop_front();
            e.pd_old = dispatch_pd_old;
            e.pc = dispatch_pc;
            e.done = 1'b0;
            tail_m = tail_m + 1'b1;
        end
        // pd_old of the previous retirement lands in the free list now
        if (rv_exp) fl_q.push_back(rv_entry.pd_old);
        // walk hands back the youngest squashed register
        if (squash_q.size() > 0) begin
            sq = squash_q.pop_back();
            fl_q.push_back(sq.pd_new);
        end
        rv_exp = retire_now;
        if (retire_now) rv_entry = rob_q.pop_front();
        if (fu_alu_done) mark(fu_alu_tag);
        if (fu_b_done) mark(fu_b_tag);
        if (fu_mem_done) mark(fu_mem_tag);
        if (take) rob_q.push_back(e);
        if (br_mispredict && idle_m) begin
            idx = -1;
            foreach (rob_q[i]) begin
                if (rob_q[i].tag == br_mispredict_tag) idx = i;
            end
            if (idx < 0) begin
                errors++;
                $display("mispredict at %0t names tag %0d, which is not in flight",
                    $time, br_mispredict_tag);
            end else begin
                while (rob_q.size() > idx + 1) squash_q.push_front(rob_q.pop_back());
                tail_m = br_mispredict_tag + 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            rob_q.delete();
            squash_q.delete();
            fl_q.delete();
            for (int p = rob_pkg::NUM_AREGS; p < rob_pkg::NUM_PREGS; p++) begin
                fl_q.push_back(rob_pkg::PREG_W'(p));
            end
            tail_m = '0;
            rv_exp = 1'b0;
        end else begin
            step();
        end
    end

endmodule

//--- testbench/rename_retire_tb.sv
module rename_retire_tb;

    localparam int OP_IDLE = 0;
    localparam int OP_DISP = 1;
    localparam int OP_COMP = 2;
    localparam int OP_MISP = 3;

    // arg: pd_old for dispatch, live position for complete and mispredict
    // arg -1 picks at random, arg -2 on a complete uses the raw tag
    typedef struct {
        int          op;
        int          tag;
        int          arg;
        logic [31:0] pc;
        int          rep;
    } row_t;

    row_t rows[$];
    int   live_tags[$];

    logic                           clk;
    logic                           reset;
    logic                           dispatch_valid;
    logic [rob_pkg::PREG_W-1:0]     dispatch_pd_old;
    logic [31:0]                    dispatch_pc;
    logic                           dispatch_ready;
    logic [rob_pkg::ROB_TAG_W-1:0]  dispatch_tag;
    logic [rob_pkg::PREG_W-1:0]     dispatch_pd_new;
    logic                           fu_alu_done;
    logic [rob_pkg::ROB_TAG_W-1:0]  fu_alu_tag;
    logic                           fu_b_done;
    logic [rob_pkg::ROB_TAG_W-1:0]  fu_b_tag;
    logic                           fu_mem_done;
    logic [rob_pkg::ROB_TAG_W-1:0]  fu_mem_tag;
    logic                           br_mispredict;
    logic [rob_pkg::ROB_TAG_W-1:0]  br_mispredict_tag;
    logic                           retire_valid;
    logic [rob_pkg::ROB_TAG_W-1:0]  retire_tag;
    logic [rob_pkg::PREG_W-1:0]     retire_pd_old;
    logic [31:0]                    retire_pc;

    logic [31:0] lfsr_state = 32'hc633;
    int          errors;
    int          cycles = 0;
    int          limit = 0;
    int          timeouts = 0;

    rename_retire_top rename_retire_top_i (.*);

    rename_retire_checker rename_retire_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32, 22, 2, 1; one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic add_row(input int op, input int tag, input int arg,
                           input logic [31:0] pc, input int rep);
        row_t r;
        r.op = op;
        r.tag = tag;
        r.arg = arg;
        r.pc = pc;
        r.rep = rep;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int sel;
        add_row(OP_DISP, 0, 10, 32'h1000, 4);
        // out of order completion, head last
        add_row(OP_COMP, 0, 2, 32'h0, 1);
        add_row(OP_COMP, 0, 1, 32'h0, 1);
        add_row(OP_COMP, 0, 3, 32'h0, 1);
        add_row(OP_COMP, 0, 0, 32'h0, 1);
        add_row(OP_IDLE, 0, 0, 32'h0, 4);
        // fill the ROB, then free one slot
        add_row(OP_DISP, 0, 20, 32'h2000, 16);
        add_row(OP_IDLE, 0, 0, 32'h0, 3);
        add_row(OP_COMP, 0, 0, 32'h0, 1);
        add_row(OP_DISP, 0, 60, 32'h2100, 1);
        add_row(OP_IDLE, 0, 0, 32'h0, 2);
        // branch at tag 10 squashes ten younger entries
        add_row(OP_MISP, 0, 5, 32'h0, 1);
        add_row(OP_IDLE, 0, 0, 32'h0, 14);
        add_row(OP_COMP, 12, -2, 32'h0, 1);
        add_row(OP_DISP, 0, 70, 32'h3000, 2);
        // youngest entry mispredicts, nothing to walk
        add_row(OP_MISP, 0, 99, 32'h0, 1);
        add_row(OP_IDLE, 0, 0, 32'h0, 2);
        for (int k = 0; k < 80; k++) begin
            sel = int'(lfsr_bits(4));
            if (sel < 6) begin
                add_row(OP_DISP, 0, -1, 32'h4000 + 32'(k * 64), 1 + int'(lfsr_bits(2)));
            end else if (sel < 13) begin
                add_row(OP_COMP, 0, -1, 32'h0, 2);
            end else if (sel == 13) begin
                add_row(OP_COMP, int'(lfsr_bits(4)), -2, 32'h0, 1);
            end else begin
                add_row(OP_MISP, 0, -1, 32'h0, 1);
                add_row(OP_IDLE, 0, 0, 32'h0, 18);
            end
        end
        add_row(OP_IDLE, 0, 0, 32'h0, 20);
    endtask

    task automatic drive_done(input int port, input int tag, input logic fire);
        fu_alu_done = fire && port == 0;
        fu_b_done = fire && port == 1;
        fu_mem_done = fire && port == 2;
        fu_alu_tag = rob_pkg::ROB_TAG_W'(tag);
        fu_b_tag = rob_pkg::ROB_TAG_W'(tag);
        fu_mem_tag = rob_pkg::ROB_TAG_W'(tag);
        @(posedge clk);
        #5;
        fu_alu_done = 1'b0;
        fu_b_done = 1'b0;
        fu_mem_done = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        int   pos;
        int   lo;
        int   port;
        int   tag;
        int   stall;
        logic fire;
        case (r.op)
            OP_DISP: begin
                for (int i = 0; i < r.rep; i++) begin
                    dispatch_valid = 1'b1;
                    if (r.arg < 0) begin
                        dispatch_pd_old = rob_pkg::PREG_W'(lfsr_bits(7));
                    end else begin
                        dispatch_pd_old = rob_pkg::PREG_W'(r.arg + i);
                    end
                    dispatch_pc = r.pc + 32'(4 * i);
                    stall = 0;
                    forever begin
                        @(posedge clk);
                        if (dispatch_ready) break;
                        #5;
                        stall++;
                        // random rows nudge the head along when stuck
                        fu_mem_done = r.arg < 0 && stall > 3 && live_tags.size() > 0;
                        if (fu_mem_done) fu_mem_tag = rob_pkg::ROB_TAG_W'(live_tags[0]);
                    end
                    #5;
                    fu_mem_done = 1'b0;
                    dispatch_valid = 1'b0;
                end
            end
            OP_COMP: begin
                for (int i = 0; i < r.rep; i++) begin
                    port = (r.arg < 0) ? int'(lfsr_bits(2)) % 3 : i % 3;
                    if (r.arg == -2) begin
                        tag = r.tag;
                        fire = 1'b1;
                    end else begin
                        pos = (r.arg < 0) ? int'(lfsr_bits(2)) : r.arg;
                        fire = pos < live_tags.size();
                        tag = fire ? live_tags[pos] : 0;
                    end
                    drive_done(port, tag, fire);
                end
            end
            OP_MISP: begin
                // front entry may have retired on the last edge
                lo = retire_valid ? 1 : 0;
                if (live_tags.size() > lo) begin
                    if (r.arg < 0) begin
                        pos = lo + int'(lfsr_bits(4)) % (live_tags.size() - lo);
                    end else begin
                        pos = r.arg + lo;
                    end
                    if (pos > live_tags.size() - 1) pos = live_tags.size() - 1;
                    br_mispredict = 1'b1;
                    br_mispredict_tag = rob_pkg::ROB_TAG_W'(live_tags[pos]);
                    while (live_tags.size() > pos + 1) void'(live_tags.pop_back());
                end
                @(posedge clk);
                #5;
                br_mispredict = 1'b0;
            end
            default: begin
                repeat (r.rep) @(posedge clk);
                #5;
            end
        endcase
    endtask

    // tags in flight, for picking completion and mispredict targets
    always @(posedge clk) begin
        if (!reset) begin
            if (retire_valid && live_tags.size() > 0) void'(live_tags.pop_front());
            if (dispatch_valid && dispatch_ready) live_tags.push_back(int'(dispatch_tag));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            timeouts++;
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pd_old = '0;
        dispatch_pc = '0;
        fu_alu_done = 1'b0;
        fu_alu_tag = '0;
        fu_b_done = 1'b0;
        fu_b_tag = '0;
        fu_mem_done = 1'b0;
        fu_mem_tag = '0;
        br_mispredict = 1'b0;
        br_mispredict_tag = '0;
        build_table();
        limit = 20 * rows.size() + 200;
        repeat (4) @(posedge clk);
        #5;
        reset = 1'b0;
        foreach (rows[i]) apply_row(rows[i]);
        repeat (4) @(posedge clk);
        #5;
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog/free_list.sv
module free_list (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pop,
    input  logic                        push_en,
    input  logic [rob_pkg::PREG_W-1:0]  push_data,
    output logic [rob_pkg::PREG_W-1:0]  pop_data,
    output logic                        empty
);

    logic [rob_pkg::PREG_W-1:0]           mem [rob_pkg::FL_DEPTH];
    logic [$clog2(rob_pkg::FL_DEPTH)-1:0] rd_ptr;
    logic [$clog2(rob_pkg::FL_DEPTH)-1:0] wr_ptr;
    logic [rob_pkg::FL_CNT_W-1:0]         count;

    assign pop_data = mem[rd_ptr];
    assign empty    = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            // every register past the architectural ones starts free, in order
            for (int i = 0; i < rob_pkg::NUM_PREGS - rob_pkg::NUM_AREGS; i++) begin
                mem[i] <= rob_pkg::PREG_W'(rob_pkg::NUM_AREGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= $clog2(rob_pkg::FL_DEPTH)'(rob_pkg::NUM_PREGS - rob_pkg::NUM_AREGS);
            count  <= rob_pkg::FL_CNT_W'(rob_pkg::NUM_PREGS - rob_pkg::NUM_AREGS);
        end else begin
            if (push_en) begin
                mem[wr_ptr] <= push_data;
                wr_ptr      <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({push_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // only registers handed out earlier come back, so it never overflows
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        push_en |-> count < rob_pkg::FL_CNT_W'(rob_pkg::FL_DEPTH));

endmodule

//--- verilog/rename_retire_top.sv
module rename_retire_top (
    input  logic                           clk,
    input  logic                           reset,

    // dispatch
    input  logic                           dispatch_valid,
    input  logic [rob_pkg::PREG_W-1:0]     dispatch_pd_old,
    input  logic [31:0]                    dispatch_pc,
    output logic                           dispatch_ready,
    output logic [rob_pkg::ROB_TAG_W-1:0]  dispatch_tag,
    output logic [rob_pkg::PREG_W-1:0]     dispatch_pd_new,

    // completion from the functional units
    input  logic                           fu_alu_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_alu_tag,
    input  logic                           fu_b_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_b_tag,
    input  logic                           fu_mem_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_mem_tag,

    // branch resolution
    input  logic                           br_mispredict,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  br_mispredict_tag,

    // retirement
    output logic                           retire_valid,
    output logic [rob_pkg::ROB_TAG_W-1:0]  retire_tag,
    output logic [rob_pkg::PREG_W-1:0]     retire_pd_old,
    output logic [31:0]                    retire_pc
);

    logic [rob_pkg::ROB_TAG_W-1:0] head;
    logic [rob_pkg::ROB_TAG_W-1:0] tail;
    logic [rob_pkg::ROB_CNT_W-1:0] rob_count;
    logic                          rob_full;
    logic                          rob_empty;

    logic                          recovery_idle;
    logic                          walk_active;
    logic [rob_pkg::ROB_TAG_W-1:0] walk_idx;
    logic                          rollback;
    logic [rob_pkg::PREG_W-1:0]    walk_pd_new;

    logic                          do_dispatch;
    logic                          do_retire;
    logic                          retire_allow;

    logic                          fl_empty;
    logic                          fl_push;
    logic [rob_pkg::PREG_W-1:0]    fl_push_data;

    // nothing moves while a mispredict is taken or being unwound
    assign retire_allow   = recovery_idle && !br_mispredict;
    assign dispatch_ready = !rob_full && !fl_empty && retire_allow;
    assign do_dispatch    = dispatch_valid && dispatch_ready;
    assign dispatch_tag   = tail;

    // retired pd_old goes back on the edge after the retirement
    // walk and retire pushes are never in the same cycle
    assign fl_push      = retire_valid || walk_active;
    assign fl_push_data = walk_active ? walk_pd_new : retire_pd_old;

    rob_ptrs rob_ptrs_i (
        .clk          (clk),
        .reset        (reset),
        .do_dispatch  (do_dispatch),
        .do_retire    (do_retire),
        .rollback     (rollback),
        .rollback_tag (br_mispredict_tag),
        .head         (head),
        .tail         (tail),
        .count        (rob_count),
        .full         (rob_full),
        .empty        (rob_empty)
    );

    rob_recovery_fsm rob_recovery_fsm_i (
        .clk               (clk),
        .reset             (reset),
        .br_mispredict     (br_mispredict),
        .br_mispredict_tag (br_mispredict_tag),
        .tail              (tail),
        .count             (rob_count),
        .head              (head),
        .recovery_idle     (recovery_idle),
        .walk_active       (walk_active),
        .walk_idx          (walk_idx),
        .rollback          (rollback)
    );

    rob_table rob_table_i (
        .clk             (clk),
        .reset           (reset),
        .do_dispatch     (do_dispatch),
        .tail            (tail),
        .head            (head),
        .dispatch_pd_new (dispatch_pd_new),
        .dispatch_pd_old (dispatch_pd_old),
        .dispatch_pc     (dispatch_pc),
        .fu_alu_done     (fu_alu_done),
        .fu_alu_tag      (fu_alu_tag),
        .fu_b_done       (fu_b_done),
        .fu_b_tag        (fu_b_tag),
        .fu_mem_done     (fu_mem_done),
        .fu_mem_tag      (fu_mem_tag),
        .walk_active     (walk_active),
        .walk_idx        (walk_idx),
        .retire_allow    (retire_allow),
        .do_retire       (do_retire),
        .walk_pd_new     (walk_pd_new),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .retire_pd_old   (retire_pd_old),
        .retire_pc       (retire_pc)
    );

    free_list free_list_i (
        .clk       (clk),
        .reset     (reset),
        .pop       (do_dispatch),
        .push_en   (fl_push),
        .push_data (fl_push_data),
        .pop_data  (dispatch_pd_new),
        .empty     (fl_empty)
    );

    // row valid bits and the occupancy counter have to agree
    a_empty_no_retire: assert property (@(posedge clk) disable iff (reset)
        rob_empty |-> !do_retire);

endmodule

//--- verilog/rob_pkg.sv
package rob_pkg;

    // reorder buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int ROB_TAG_W = 4;
    localparam int ROB_CNT_W = 5;

    // physical register file
    localparam int PREG_W    = 7;
    localparam int NUM_PREGS = 128;

    // p0..p31 hold the initial architectural mapping
    localparam int NUM_AREGS = 32;

    // free list sized for every physical register
    localparam int FL_DEPTH  = 128;
    localparam int FL_CNT_W  = 8;

    // one ROB row
    typedef struct packed {
        logic              valid;
        logic              complete;
        logic [PREG_W-1:0] pd_new;
        logic [PREG_W-1:0] pd_old;
        logic [31:0]       pc;
    } rob_entry_t;

endpackage

//--- verilog/rob_ptrs.sv
module rob_ptrs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           do_dispatch,
    input  logic                           do_retire,
    input  logic                           rollback,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  rollback_tag,
    output logic [rob_pkg::ROB_TAG_W-1:0]  head,
    output logic [rob_pkg::ROB_TAG_W-1:0]  tail,
    output logic [rob_pkg::ROB_CNT_W-1:0]  count,
    output logic                           full,
    output logic                           empty
);

    logic [rob_pkg::ROB_TAG_W-1:0] new_tail;
    logic [rob_pkg::ROB_TAG_W-1:0] span;

    // tail after rollback sits just past the mispredicted branch
    assign new_tail = rollback_tag + 1'b1;
    assign span     = new_tail - head;

    assign full  = (count == rob_pkg::ROB_CNT_W'(rob_pkg::ROB_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (rollback) begin
            tail <= new_tail;
            // head == new tail with entries left means the ROB stays full
            if (span == '0 && count != '0) begin
                count <= rob_pkg::ROB_CNT_W'(rob_pkg::ROB_DEPTH);
            end else begin
                count <= {1'b0, span};
            end
        end else begin
            // 4-bit pointers wrap on their own
            if (do_dispatch) begin
                tail <= tail + 1'b1;
            end
            if (do_retire) begin
                head <= head + 1'b1;
            end
            unique case ({do_retire, do_dispatch})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= rob_pkg::ROB_CNT_W'(rob_pkg::ROB_DEPTH));

endmodule

//--- verilog/rob_recovery_fsm.sv
module rob_recovery_fsm (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           br_mispredict,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  br_mispredict_tag,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  tail,
    input  logic [rob_pkg::ROB_CNT_W-1:0]  count,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  head,
    output logic                           recovery_idle,
    output logic                           walk_active,
    output logic [rob_pkg::ROB_TAG_W-1:0]  walk_idx,
    output logic                           rollback
);

    typedef enum logic {
        IDLE,
        WALK
    } state_t;

    state_t state;

    logic [rob_pkg::ROB_TAG_W-1:0] age;
    logic [rob_pkg::ROB_CNT_W-1:0] n_squash;
    logic [rob_pkg::ROB_CNT_W-1:0] remaining;

    // position of the branch counted from the oldest entry
    assign age = br_mispredict_tag - head;

    // everything younger than the branch is squashed
    assign n_squash = count - {1'b0, age} - 1'b1;

    assign recovery_idle = (state == IDLE);
    assign walk_active   = (state == WALK);
    assign rollback      = br_mispredict && (state == IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            remaining <= '0;
            walk_idx  <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (rollback && n_squash != '0) begin
                        // start at the youngest entry
                        walk_idx  <= tail - 1'b1;
                        remaining <= n_squash;
                        state     <= WALK;
                    end
                end
                WALK: begin
                    walk_idx  <= walk_idx - 1'b1;
                    remaining <= remaining - 1'b1;
                    if (remaining == 1) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the branch unit must hold off a second mispredict until the walk ends
    a_no_mispredict_in_walk: assert property (@(posedge clk) disable iff (reset)
        (state == WALK) |-> !br_mispredict);

endmodule

//--- verilog/rob_table.sv
module rob_table (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           do_dispatch,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  tail,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  head,
    input  logic [rob_pkg::PREG_W-1:0]     dispatch_pd_new,
    input  logic [rob_pkg::PREG_W-1:0]     dispatch_pd_old,
    input  logic [31:0]                    dispatch_pc,
    input  logic                           fu_alu_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_alu_tag,
    input  logic                           fu_b_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_b_tag,
    input  logic                           fu_mem_done,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  fu_mem_tag,
    input  logic                           walk_active,
    input  logic [rob_pkg::ROB_TAG_W-1:0]  walk_idx,
    input  logic                           retire_allow,
    output logic                           do_retire,
    output logic [rob_pkg::PREG_W-1:0]     walk_pd_new,
    output logic                           retire_valid,
    output logic [rob_pkg::ROB_TAG_W-1:0]  retire_tag,
    output logic [rob_pkg::PREG_W-1:0]     retire_pd_old,
    output logic [31:0]                    retire_pc
);

    rob_pkg::rob_entry_t rows [rob_pkg::ROB_DEPTH];

    // oldest entry leaves once it has finished
    assign do_retire = rows[head].valid && rows[head].complete && retire_allow;

    // register to hand back during the squash walk
    assign walk_pd_new = rows[walk_idx].pd_new;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                rows[i].valid    <= 1'b0;
                rows[i].complete <= 1'b0;
            end
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= do_retire;

            // completions only count on live entries
            if (fu_alu_done && rows[fu_alu_tag].valid) begin
                rows[fu_alu_tag].complete <= 1'b1;
            end
            if (fu_b_done && rows[fu_b_tag].valid) begin
                rows[fu_b_tag].complete <= 1'b1;
            end
            if (fu_mem_done && rows[fu_mem_tag].valid) begin
                rows[fu_mem_tag].complete <= 1'b1;
            end

            // clears come after completions so they win on the same row
            if (do_retire) begin
                rows[head].valid    <= 1'b0;
                rows[head].complete <= 1'b0;
            end
            if (walk_active) begin
                rows[walk_idx].valid    <= 1'b0;
                rows[walk_idx].complete <= 1'b0;
            end

            if (do_dispatch) begin
                rows[tail] <= '{
                    valid:    1'b1,
                    complete: 1'b0,
                    pd_new:   dispatch_pd_new,
                    pd_old:   dispatch_pd_old,
                    pc:       dispatch_pc
                };
            end
        end
    end

    // retirement payload, qualified by retire_valid
    always_ff @(posedge clk) begin
        if (do_retire) begin
            retire_tag    <= head;
            retire_pd_old <= rows[head].pd_old;
            retire_pc     <= rows[head].pc;
        end
    end

    // pointers must never let a dispatch land on a live row
    a_dispatch_row_free: assert property (@(posedge clk) disable iff (reset)
        do_dispatch |-> !rows[tail].valid);

endmodule
